/* flist.f */
source/lsu_pkg.sv
source/data_trigger.sv
source/dmem_sram.sv
source/lsu_core.sv
source/lsu_subsys_top.sv
tb/lsu_checker.sv
tb/tb_lsu_subsys.sv

/* tb/tb_lsu_subsys.sv */
// Testbench top for the load/store subsystem
// Clock, reset, LFSR stimulus, DUT, checker and watchdog

module tb_lsu_subsys;

    import lsu_pkg::*;

    localparam int MEM_WORDS      = 256;
    localparam int MEM_LATENCY    = 2;
    localparam int CLK_PERIOD     = 10;
    localparam int NUM_TXN        = 600;        // Fill plus random phases
    localparam int CYCLES_PER_TXN = 20;
    localparam int PHASE_TXN      = 86;         // 256 + 4 * 86 = 600

    logic        clk;
    logic        rst_n;
    logic        req;
    exu_req_s    exu_req;
    lsu_resp_s   resp;
    trig_cfg_s   trig_cfg;
    logic [15:0] trig_hits;
    logic [31:0] lfsr_q;
    int          err_cnt;
    int          chk_cnt;

    always #(CLK_PERIOD / 2) clk = ~clk;

    lsu_subsys_top #(
        .MEM_WORDS   (MEM_WORDS),
        .MEM_LATENCY (MEM_LATENCY)
    ) lsu_subsys_top_inst (
        .clk         (clk),
        .rst_n       (rst_n),
        .req_i       (req),
        .exu_req_i   (exu_req),
        .resp_o      (resp),
        .trig_cfg_i  (trig_cfg),
        .trig_hits_o (trig_hits)
    );

    lsu_checker #(
        .MEM_WORDS   (MEM_WORDS),
        .MEM_LATENCY (MEM_LATENCY)
    ) checker_inst (
        .clk         (clk),
        .rst_n       (rst_n),
        .req_i       (req),
        .exu_req_i   (exu_req),
        .resp_i      (resp),
        .trig_cfg_i  (trig_cfg),
        .trig_hits_i (trig_hits),
        .err_cnt_o   (err_cnt),
        .chk_cnt_o   (chk_cnt)
    );

    // ------------------------------------------------------------------
    // Stimulus helpers
    // ------------------------------------------------------------------

    // Taps 32, 22, 2, 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic take_bits(input int n, output logic [31:0] val);
        val = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_q = lfsr_step(lfsr_q);
            val    = {val[30:0], lfsr_q[0]};     // One step per bit
        end
    endtask

    // Hold the request until rdy or exc, drop it on the next falling edge
    task automatic issue(input lsu_cmd_e cmd, input logic [31:0] addr,
                         input logic [31:0] sdata);
        @(negedge clk);
        req           = 1'b1;
        exu_req.cmd   = cmd;
        exu_req.addr  = addr;
        exu_req.sdata = sdata;
        @(posedge clk);
        while (!(resp.rdy || resp.exc)) begin
            @(posedge clk);
        end
        @(negedge clk);
        req = 1'b0;
    endtask

    task automatic random_txn(input logic [7:0] hot_word);
        logic [31:0] r;
        logic [31:0] sdata;
        logic [7:0]  word;
        logic [1:0]  low;
        logic        misalign;
        logic        far;
        lsu_cmd_e    cmd;
        take_bits(3, r);
        case (r[2:0])
            3'd0:    cmd = LSU_CMD_LB;
            3'd1:    cmd = LSU_CMD_LH;
            3'd2:    cmd = LSU_CMD_LW;
            3'd3:    cmd = LSU_CMD_LBU;
            3'd4:    cmd = LSU_CMD_LHU;
            3'd5:    cmd = LSU_CMD_SB;
            3'd6:    cmd = LSU_CMD_SH;
            default: cmd = LSU_CMD_SW;
        endcase
        take_bits(8, r);
        word = r[7:0];
        take_bits(2, r);
        if (r[1:0] == 2'd0) begin
            word = hot_word;                        // Aim at the trigger word
        end
        take_bits(2, r);
        misalign = (r[1:0] == 2'd0);                // About one in four
        take_bits(2, r);
        low = r[1:0];
        if (misalign) begin
            low = {low[1], 1'b1};                   // Odd offset
        end else if (cmd inside {LSU_CMD_LH, LSU_CMD_LHU, LSU_CMD_SH}) begin
            low[0] = 1'b0;
        end else if (cmd inside {LSU_CMD_LW, LSU_CMD_SW}) begin
            low = 2'b00;
        end
        take_bits(3, r);
        far = (r[2:0] == 3'd0);                     // About one in eight
        take_bits(32, sdata);
        issue(cmd, (far ? 32'(MEM_WORDS * 4) : 32'd0) + {22'b0, word, low}, sdata);
    endtask

    task automatic run_phase(input logic en, input logic on_load, input logic on_store,
                             input logic [7:0] hot_word);
        @(negedge clk);
        trig_cfg.en       = en;
        trig_cfg.addr     = {22'b0, hot_word, 2'b01};   // Byte offset ignored by trigger
        trig_cfg.on_load  = on_load;
        trig_cfg.on_store = on_store;
        for (int i = 0; i < PHASE_TXN; i++) begin
            random_txn(hot_word);
        end
    endtask

    // ------------------------------------------------------------------
    // Main sequence
    // ------------------------------------------------------------------

    initial begin
        logic [31:0] d;
        clk      = 1'b0;
        rst_n    = 1'b0;
        req      = 1'b0;
        exu_req  = '0;
        trig_cfg = '0;
        lfsr_q   = 32'hbe1e;
        repeat (4) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        repeat (3) @(negedge clk);                  // Quiet response after reset

        // Fill every word, data mixed with the address
        for (int w = 0; w < MEM_WORDS; w++) begin
            take_bits(32, d);
            issue(LSU_CMD_SW, 32'(w * 4), d ^ (32'(w) * 32'h0101_0101));
        end

        run_phase(1'b0, 1'b0, 1'b0, 8'h3c);
        run_phase(1'b1, 1'b1, 1'b0, 8'h51);         // Loads only
        run_phase(1'b1, 1'b0, 1'b1, 8'h9a);         // Stores only
        run_phase(1'b1, 1'b1, 1'b1, 8'he7);

        repeat (4) @(negedge clk);
        $display("Checks: %0d, errors: %0d", chk_cnt, err_cnt);
        if (err_cnt == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

    initial begin : watchdog
        #(NUM_TXN * CYCLES_PER_TXN * CLK_PERIOD);
        $display("Timeout: run did not complete within %0d cycles",
                 NUM_TXN * CYCLES_PER_TXN);
        $display("ERRORS FOUND");
        $finish;
    end

endmodule

/* tb/lsu_checker.sv */
// Response checker for the load/store subsystem
// Byte memory model, response prediction and error counting

module lsu_checker #(
    parameter int MEM_WORDS   = 256,
    parameter int MEM_LATENCY = 2
) (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               req_i,
    input  lsu_pkg::exu_req_s  exu_req_i,
    input  lsu_pkg::lsu_resp_s resp_i,
    input  lsu_pkg::trig_cfg_s trig_cfg_i,
    input  logic [15:0]        trig_hits_i,
    output int                 err_cnt_o,
    output int                 chk_cnt_o
);

    import lsu_pkg::*;

    localparam int MEM_BYTES = MEM_WORDS * 4;

    logic [7:0]  model_mem [MEM_BYTES];     // x until first store
    logic        pending;                   // Legal access in flight
    int          wait_cnt;                  // Edges since the accepting edge
    exu_req_s    pend_req;
    logic [15:0] exp_hits;

    initial begin
        err_cnt_o = 0;
        chk_cnt_o = 0;
    end

    task automatic compare_val(input string what, input logic [31:0] got,
                               input logic [31:0] exp);
        chk_cnt_o++;
        if (got !== exp) begin
            err_cnt_o++;
            $display("[FAIL] %0t: %s is %h, expected %h", $time, what, got, exp);
        end
    endtask

    function automatic logic is_load_cmd(input lsu_cmd_e c);
        return c inside {LSU_CMD_LB, LSU_CMD_LH, LSU_CMD_LW, LSU_CMD_LBU, LSU_CMD_LHU};
    endfunction

    function automatic logic is_store_cmd(input lsu_cmd_e c);
        return c inside {LSU_CMD_SB, LSU_CMD_SH, LSU_CMD_SW};
    endfunction

    // ------------------------------------------------------------------
    // Prediction
    // ------------------------------------------------------------------

    // Breakpoint beats misalign, both seen in the request cycle
    function automatic exc_code_e request_exc(input exu_req_s r, input trig_cfg_s cfg);
        logic bad_align;
        logic kind_hit;
        bad_align = ((r.cmd inside {LSU_CMD_LH, LSU_CMD_LHU, LSU_CMD_SH}) && r.addr[0])
                  || ((r.cmd inside {LSU_CMD_LW, LSU_CMD_SW}) && (r.addr[1:0] != 2'b00));
        kind_hit  = (is_load_cmd(r.cmd) && cfg.on_load) || (is_store_cmd(r.cmd) && cfg.on_store);
        if (cfg.en && kind_hit && (r.addr[31:2] == cfg.addr[31:2])) begin
            return EXC_CODE_BREAKPOINT;
        end
        if (bad_align) begin
            return is_load_cmd(r.cmd) ? EXC_CODE_LD_ADDR_MISALIGN : EXC_CODE_ST_ADDR_MISALIGN;
        end
        return EXC_CODE_NONE;
    endfunction

    // Little-endian bytes, extended as the command says
    function automatic logic [31:0] expected_load(input exu_req_s r);
        logic [31:0] a;
        a = r.addr;
        case (r.cmd)
            LSU_CMD_LB:  return {{24{model_mem[a][7]}}, model_mem[a]};
            LSU_CMD_LBU: return {24'b0, model_mem[a]};
            LSU_CMD_LH:  return {{16{model_mem[a+1][7]}}, model_mem[a+1], model_mem[a]};
            LSU_CMD_LHU: return {16'b0, model_mem[a+1], model_mem[a]};
            default:     return {model_mem[a+3], model_mem[a+2], model_mem[a+1], model_mem[a]};
        endcase
    endfunction

    task automatic finish_access(input exu_req_s r);
        logic  in_range;
        string tag;
        in_range = r.addr < 32'(MEM_BYTES);
        tag      = $sformatf("%s @%h", r.cmd.name(), r.addr);
        compare_val({"rdy after latency, ", tag}, resp_i.rdy, 1'b1);
        compare_val({"exc at completion, ", tag}, resp_i.exc, !in_range);
        if (!in_range) begin                // Aligned but beyond the RAM
            compare_val({"fault code, ", tag}, resp_i.exc_code,
                        is_load_cmd(r.cmd) ? EXC_CODE_LD_ACCESS_FAULT
                                           : EXC_CODE_ST_ACCESS_FAULT);
        end else begin
            compare_val({"exc_code, ", tag}, resp_i.exc_code, EXC_CODE_NONE);
            if (is_load_cmd(r.cmd)) begin
                compare_val({"ldata, ", tag}, resp_i.ldata, expected_load(r));
            end else begin
                model_mem[r.addr] = r.sdata[7:0];
                if (r.cmd != LSU_CMD_SB) begin
                    model_mem[r.addr+1] = r.sdata[15:8];
                end
                if (r.cmd == LSU_CMD_SW) begin
                    model_mem[r.addr+2] = r.sdata[23:16];
                    model_mem[r.addr+3] = r.sdata[31:24];
                end
            end
        end
    endtask

    // ------------------------------------------------------------------
    // Per-edge comparison, pre-edge values
    // ------------------------------------------------------------------

    always @(posedge clk) begin
        exc_code_e exp_code;
        if (!rst_n) begin
            pending  = 1'b0;
            exp_hits = '0;
            compare_val("rdy in reset", resp_i.rdy, 1'b0);
            compare_val("exc in reset", resp_i.exc, 1'b0);
        end else begin
            compare_val("trigger hit count", trig_hits_i, exp_hits);
            if (pending) begin
                wait_cnt++;
                if (wait_cnt == MEM_LATENCY) begin
                    finish_access(pend_req);
                    pending = 1'b0;
                end else begin
                    compare_val("rdy before latency", resp_i.rdy, 1'b0);
                    compare_val("exc while busy", resp_i.exc, 1'b0);
                end
            end else if (req_i) begin
                exp_code = request_exc(exu_req_i, trig_cfg_i);
                compare_val("rdy in request cycle", resp_i.rdy, 1'b0);
                compare_val("exc in request cycle", resp_i.exc, exp_code != EXC_CODE_NONE);
                if (exp_code != EXC_CODE_NONE) begin
                    compare_val($sformatf("exc_code, %s @%h", exu_req_i.cmd.name(),
                                          exu_req_i.addr), resp_i.exc_code, exp_code);
                    if (exp_code == EXC_CODE_BREAKPOINT) begin
                        exp_hits++;
                    end
                end else begin
                    pending  = 1'b1;        // Memory takes it on this edge
                    wait_cnt = 0;
                    pend_req = exu_req_i;
                end
            end else begin
                compare_val("rdy while idle", resp_i.rdy, 1'b0);
                compare_val("exc while idle", resp_i.exc, 1'b0);
            end
        end
    end

endmodule

/* source/lsu_subsys_top.sv */
// Data side top level
// Load/store unit, data RAM and data trigger

module lsu_subsys_top #(
    parameter int MEM_WORDS   = 256,
    parameter int MEM_LATENCY = 2
) (
    input  logic                clk,
    input  logic                rst_n,
    // Execution stage port
    input  logic                req_i,
    input  lsu_pkg::exu_req_s   exu_req_i,
    output lsu_pkg::lsu_resp_s  resp_o,
    // Debug
    input  lsu_pkg::trig_cfg_s  trig_cfg_i,
    output logic [15:0]         trig_hits_o
);

    import lsu_pkg::*;

    // ----------------------------------------------------------------------
    // Internal wiring
    // ----------------------------------------------------------------------

    logic             dmem_req;
    dmem_req_s        dmem_req_data;
    logic             dmem_ack;
    logic [XLEN-1:0]  dmem_rdata;
    mem_resp_e        dmem_resp;
    dmon_s            dmon;
    logic             dbrk;           // Breakpoint back to the LSU

    lsu_core lsu_core_inst (
        .clk          (clk),
        .rst_n        (rst_n),
        .req_i        (req_i),
        .exu_req_i    (exu_req_i),
        .resp_o       (resp_o),
        .dmon_o       (dmon),
        .dbrk_i       (dbrk),
        .dmem_req_o   (dmem_req),
        .dmem_o       (dmem_req_data),
        .dmem_ack_i   (dmem_ack),
        .dmem_rdata_i (dmem_rdata),
        .dmem_resp_i  (dmem_resp)
    );

    dmem_sram #(
        .MEM_WORDS   (MEM_WORDS),
        .MEM_LATENCY (MEM_LATENCY)
    ) dmem_sram_inst (
        .clk        (clk),
        .rst_n      (rst_n),
        .req_i      (dmem_req),
        .req_data_i (dmem_req_data),
        .ack_o      (dmem_ack),
        .rdata_o    (dmem_rdata),
        .resp_o     (dmem_resp)
    );

    data_trigger data_trigger_inst (
        .clk       (clk),
        .rst_n     (rst_n),
        .cfg_i     (trig_cfg_i),
        .dmon_i    (dmon),
        .dbrk_o    (dbrk),
        .hit_cnt_o (trig_hits_o)
    );

endmodule

/* source/lsu_core.sv */
// Load/store unit
// Idle/busy FSM, exception priority and load data extension

module lsu_core (
    input  logic                    clk,
    input  logic                    rst_n,
    // Execution stage side
    input  logic                    req_i,          // Held until rdy or exc
    input  lsu_pkg::exu_req_s       exu_req_i,
    output lsu_pkg::lsu_resp_s      resp_o,
    // Trigger side
    output lsu_pkg::dmon_s          dmon_o,
    input  logic                    dbrk_i,         // Same-cycle breakpoint
    // Data memory side
    output logic                    dmem_req_o,
    output lsu_pkg::dmem_req_s      dmem_o,
    input  logic                    dmem_ack_i,
    input  logic [lsu_pkg::XLEN-1:0] dmem_rdata_i,  // Right-aligned
    input  lsu_pkg::mem_resp_e      dmem_resp_i
);

    import lsu_pkg::*;

    typedef enum logic {
        ST_IDLE,
        ST_BUSY
    } state_e;

    state_e     state_q;
    state_e     state_d;
    logic       fsm_idle;
    lsu_cmd_e   cmd_q;              // Command of the access in flight

    logic       cmd_load;
    logic       cmd_store;
    logic       wdth_byte;
    logic       wdth_hword;
    logic       wdth_word;
    logic       cmd_q_load;
    logic       cmd_q_store;

    logic       resp_ok;
    logic       resp_er;
    logic       resp_received;
    logic       req_accept;

    logic       addr_mslgn;
    logic       exc_req;            // Exception without memory access

    // ----------------------------------------------------------------------
    // Command decode
    // ----------------------------------------------------------------------

    assign cmd_load   = exu_req_i.cmd inside {LSU_CMD_LB, LSU_CMD_LBU, LSU_CMD_LH,
                                              LSU_CMD_LHU, LSU_CMD_LW};
    assign cmd_store  = exu_req_i.cmd inside {LSU_CMD_SB, LSU_CMD_SH, LSU_CMD_SW};
    assign wdth_byte  = exu_req_i.cmd inside {LSU_CMD_LB, LSU_CMD_LBU, LSU_CMD_SB};
    assign wdth_hword = exu_req_i.cmd inside {LSU_CMD_LH, LSU_CMD_LHU, LSU_CMD_SH};
    assign wdth_word  = exu_req_i.cmd inside {LSU_CMD_LW, LSU_CMD_SW};

    assign cmd_q_load  = cmd_q inside {LSU_CMD_LB, LSU_CMD_LBU, LSU_CMD_LH,
                                       LSU_CMD_LHU, LSU_CMD_LW};
    assign cmd_q_store = cmd_q inside {LSU_CMD_SB, LSU_CMD_SH, LSU_CMD_SW};

    assign resp_ok       = (dmem_resp_i == MEM_RESP_RDY_OK);
    assign resp_er       = (dmem_resp_i == MEM_RESP_RDY_ER);
    assign resp_received = resp_ok | resp_er;
    assign req_accept    = dmem_req_o & dmem_ack_i;

    // Keep command for extension and fault kind
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cmd_q <= LSU_CMD_NONE;
        end else if (req_accept) begin
            cmd_q <= exu_req_i.cmd;
        end
    end

    // ----------------------------------------------------------------------
    // FSM
    // ----------------------------------------------------------------------

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q <= ST_IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    always_comb begin
        state_d = state_q;
        case (state_q)
            ST_IDLE: if (req_accept)    state_d = ST_BUSY;
            ST_BUSY: if (resp_received) state_d = ST_IDLE;
            default:                    state_d = ST_IDLE;
        endcase
    end

    assign fsm_idle = (state_q == ST_IDLE);

    // ----------------------------------------------------------------------
    // Exceptions
    // ----------------------------------------------------------------------

    // Halfword on odd byte, word off a 4-byte boundary
    assign addr_mslgn = req_i & fsm_idle
                      & ((wdth_hword & exu_req_i.addr[0])
                      |  (wdth_word  & (|exu_req_i.addr[1:0])));

    assign exc_req = dbrk_i | addr_mslgn;

    // Memory error first, then breakpoint, then misalign
    always_comb begin
        resp_o.exc_code = EXC_CODE_NONE;
        if (resp_er) begin
            if (cmd_q_load)       resp_o.exc_code = EXC_CODE_LD_ACCESS_FAULT;
            else if (cmd_q_store) resp_o.exc_code = EXC_CODE_ST_ACCESS_FAULT;
        end else if (dbrk_i) begin
            resp_o.exc_code = EXC_CODE_BREAKPOINT;
        end else if (addr_mslgn & cmd_load) begin
            resp_o.exc_code = EXC_CODE_LD_ADDR_MISALIGN;
        end else if (addr_mslgn & cmd_store) begin
            resp_o.exc_code = EXC_CODE_ST_ADDR_MISALIGN;
        end
    end

    // ----------------------------------------------------------------------
    // Execution stage response
    // ----------------------------------------------------------------------

    always_comb begin
        resp_o.rdy = resp_received;
        resp_o.exc = resp_er | exc_req;        // Both high on access fault
        case (cmd_q)
            LSU_CMD_LB:  resp_o.ldata = {{24{dmem_rdata_i[7]}}, dmem_rdata_i[7:0]};
            LSU_CMD_LBU: resp_o.ldata = {24'b0, dmem_rdata_i[7:0]};
            LSU_CMD_LH:  resp_o.ldata = {{16{dmem_rdata_i[15]}}, dmem_rdata_i[15:0]};
            LSU_CMD_LHU: resp_o.ldata = {16'b0, dmem_rdata_i[15:0]};
            default:     resp_o.ldata = dmem_rdata_i;  // LW
        endcase
    end

    // ----------------------------------------------------------------------
    // Memory and trigger outputs
    // ----------------------------------------------------------------------

    assign dmem_req_o   = req_i & fsm_idle & ~exc_req;
    assign dmem_o.cmd   = cmd_store ? MEM_CMD_WR : MEM_CMD_RD;
    assign dmem_o.width = wdth_byte  ? MEM_WIDTH_BYTE
                        : wdth_hword ? MEM_WIDTH_HWORD
                                     : MEM_WIDTH_WORD;
    assign dmem_o.addr  = exu_req_i.addr;
    assign dmem_o.wdata = exu_req_i.sdata;

    assign dmon_o.vd    = req_i & fsm_idle;
    assign dmon_o.addr  = exu_req_i.addr;
    assign dmon_o.load  = cmd_load;
    assign dmon_o.store = cmd_store;

endmodule

/* source/dmem_sram.sv */
// Byte-lane data RAM with fixed response latency
// Out-of-range accesses return an error response

module dmem_sram #(
    parameter int MEM_WORDS   = 256,
    parameter int MEM_LATENCY = 2        // Cycles from accept to response, >= 1
) (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     req_i,
    input  lsu_pkg::dmem_req_s       req_data_i,
    output logic                     ack_o,
    output logic [lsu_pkg::XLEN-1:0] rdata_o,
    output lsu_pkg::mem_resp_e       resp_o
);

    import lsu_pkg::*;

    localparam int IDX_W = $clog2(MEM_WORDS);
    localparam int CNT_W = $clog2(MEM_LATENCY + 1);

    logic [XLEN-1:0]  mem [MEM_WORDS];

    logic [CNT_W-1:0] cnt_q;            // Cycles left to response
    logic             accept;
    logic             in_range;
    logic             wr_en;
    logic [IDX_W-1:0] word_idx;
    logic [3:0]       byte_en;
    logic [XLEN-1:0]  wdata_lanes;      // Store data copied onto every lane

    logic [XLEN-1:0]  rdata_q;
    mem_resp_e        resp_q;

    // ----------------------------------------------------------------------
    // Address decode and lane enables
    // ----------------------------------------------------------------------

    assign accept   = req_i & ack_o;
    assign in_range = req_data_i.addr[XLEN-1:2] < (XLEN-2)'(MEM_WORDS);
    assign word_idx = req_data_i.addr[IDX_W+1:2];
    assign wr_en    = accept & in_range & (req_data_i.cmd == MEM_CMD_WR);

    always_comb begin
        case (req_data_i.width)
            MEM_WIDTH_BYTE: begin
                byte_en     = 4'b0001 << req_data_i.addr[1:0];
                wdata_lanes = {4{req_data_i.wdata[7:0]}};
            end
            MEM_WIDTH_HWORD: begin
                byte_en     = 4'b0011 << req_data_i.addr[1:0];
                wdata_lanes = {2{req_data_i.wdata[15:0]}};
            end
            default: begin
                byte_en     = 4'b1111;
                wdata_lanes = req_data_i.wdata;
            end
        endcase
    end

    // ----------------------------------------------------------------------
    // Storage
    // ----------------------------------------------------------------------

    always_ff @(posedge clk) begin
        if (wr_en) begin
            for (int i = 0; i < 4; i++) begin
                if (byte_en[i]) mem[word_idx][8*i +: 8] <= wdata_lanes[8*i +: 8];
            end
        end
    end

    // Result captured at accept, shifted down to bit 0
    always_ff @(posedge clk) begin
        if (accept) begin
            if (in_range && req_data_i.cmd == MEM_CMD_RD) begin
                rdata_q <= mem[word_idx] >> {req_data_i.addr[1:0], 3'b000};
            end else begin
                rdata_q <= '0;
            end
            resp_q <= in_range ? MEM_RESP_RDY_OK : MEM_RESP_RDY_ER;
        end
    end

    // ----------------------------------------------------------------------
    // Latency counter
    // ----------------------------------------------------------------------

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cnt_q <= '0;
        end else if (accept) begin
            cnt_q <= CNT_W'(MEM_LATENCY);
        end else if (cnt_q != '0) begin
            cnt_q <= cnt_q - 1'b1;
        end
    end

    assign ack_o   = (cnt_q == '0);                 // Busy while counting
    assign resp_o  = (cnt_q == CNT_W'(1)) ? resp_q : MEM_RESP_NOTRDY;
    assign rdata_o = rdata_q;

endmodule

/* source/data_trigger.sv */
// Data address breakpoint comparator
// One configurable word address with load/store qualifiers and a hit counter

module data_trigger (
    input  logic                clk,
    input  logic                rst_n,
    input  lsu_pkg::trig_cfg_s  cfg_i,
    input  lsu_pkg::dmon_s      dmon_i,
    output logic                dbrk_o,      // Combinational, same cycle
    output logic [15:0]         hit_cnt_o
);

    import lsu_pkg::*;

    logic        addr_match;
    logic        kind_match;
    logic [15:0] hit_cnt_q;

    // ----------------------------------------------------------------------
    // Match logic
    // ----------------------------------------------------------------------

    // Word compare, byte offset ignored
    // so misaligned accesses still hit
    assign addr_match = (dmon_i.addr[XLEN-1:2] == cfg_i.addr[XLEN-1:2]);

    assign kind_match = (dmon_i.load  & cfg_i.on_load)
                      | (dmon_i.store & cfg_i.on_store);

    assign dbrk_o = cfg_i.en & dmon_i.vd & addr_match & kind_match;

    // ----------------------------------------------------------------------
    // Hit status
    // ----------------------------------------------------------------------

    // One count per breakpoint cycle, wraps at 16 bits
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            hit_cnt_q <= '0;
        end else if (dbrk_o) begin
            hit_cnt_q <= hit_cnt_q + 16'd1;
        end
    end

    assign hit_cnt_o = hit_cnt_q;

endmodule

/* source/lsu_pkg.sv */
// Shared types for the load/store subsystem
// Command, memory, exception enums and the bus structs

package lsu_pkg;

    // Data and address width, fixed by RV32
    localparam int XLEN = 32;

    // ----------------------------------------------------------------------
    // Enums
    // ----------------------------------------------------------------------

    typedef enum logic [3:0] {
        LSU_CMD_NONE = 4'd0,
        LSU_CMD_LB   = 4'd1,
        LSU_CMD_LH   = 4'd2,
        LSU_CMD_LW   = 4'd3,
        LSU_CMD_LBU  = 4'd4,
        LSU_CMD_LHU  = 4'd5,
        LSU_CMD_SB   = 4'd6,
        LSU_CMD_SH   = 4'd7,
        LSU_CMD_SW   = 4'd8
    } lsu_cmd_e;

    typedef enum logic {
        MEM_CMD_RD = 1'b0,
        MEM_CMD_WR = 1'b1
    } mem_cmd_e;

    typedef enum logic [1:0] {
        MEM_WIDTH_BYTE  = 2'd0,
        MEM_WIDTH_HWORD = 2'd1,
        MEM_WIDTH_WORD  = 2'd2
    } mem_width_e;

    typedef enum logic [1:0] {
        MEM_RESP_NOTRDY = 2'd0,
        MEM_RESP_RDY_OK = 2'd1,
        MEM_RESP_RDY_ER = 2'd2
    } mem_resp_e;

    // RISC-V mcause values, 0 doubles as "no exception"
    typedef enum logic [3:0] {
        EXC_CODE_NONE             = 4'd0,
        EXC_CODE_BREAKPOINT       = 4'd3,
        EXC_CODE_LD_ADDR_MISALIGN = 4'd4,
        EXC_CODE_LD_ACCESS_FAULT  = 4'd5,
        EXC_CODE_ST_ADDR_MISALIGN = 4'd6,
        EXC_CODE_ST_ACCESS_FAULT  = 4'd7
    } exc_code_e;

    // ----------------------------------------------------------------------
    // Structs
    // ----------------------------------------------------------------------

    typedef struct packed {
        lsu_cmd_e          cmd;         // 4
        logic [XLEN-1:0]   addr;        // 32
        logic [XLEN-1:0]   sdata;       // 32
    } exu_req_s;                        // 68 bits

    typedef struct packed {
        logic              rdy;         // Memory answered
        logic              exc;         // Exception taken
        exc_code_e         exc_code;
        logic [XLEN-1:0]   ldata;       // Extended load data
    } lsu_resp_s;                       // 38 bits

    typedef struct packed {
        mem_cmd_e          cmd;
        mem_width_e        width;
        logic [XLEN-1:0]   addr;
        logic [XLEN-1:0]   wdata;
    } dmem_req_s;                       // 67 bits

    typedef struct packed {
        logic              vd;          // Access under watch
        logic [XLEN-1:0]   addr;
        logic              load;
        logic              store;
    } dmon_s;                           // 35 bits

    typedef struct packed {
        logic              en;
        logic [XLEN-1:0]   addr;        // Word granular match
        logic              on_load;
        logic              on_store;
    } trig_cfg_s;                       // 35 bits

endpackage
